// File: Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, fail unless the log shows a pass"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		-f vlog.f --top-module tb_cu_control -Mdir obj_dir -o sim_cu_control
	./obj_dir/sim_cu_control > $(LOG) 2>&1; cat $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: src/cu_config_pkg.sv
// Configuration word bit positions and mode decode constants

package cu_config_pkg;

	////////////////////////////////////////////////////////////
	// Mode bits of the configuration word
	////////////////////////////////////////////////////////////

	// Read mode, response data is dropped
	localparam int unsigned CFG_READ_BIT = 23;

	// Copy mode, reads the source and writes the destination
	localparam int unsigned CFG_WRITE_BIT = 22;

	// A configure word of all zeros means no job is set up
	localparam int unsigned CFG_IDLE_VALUE = 0;

endpackage

// File: src/cu_control_top.sv
// Copy accelerator control unit top level with stage instances

module cu_control_top
	import cu_params_pkg::*;
(
	input  logic              clock,
	input  logic              rstn,
	input  logic              enabled_in,
	input  logic              wed_valid,
	input  logic [ADDR_W-1:0] wed_src_addr,
	input  logic [ADDR_W-1:0] wed_dst_addr,
	input  logic [SIZE_W-1:0] wed_size,
	input  logic [CFG_W-1:0]  cu_configure,
	input  logic              rd_credit_return,
	input  logic              rd_rsp_valid,
	input  logic [TAG_W-1:0]  rd_rsp_tag,
	input  logic [DATA_W-1:0] rd_rsp_data,
	input  logic              wr_credit_return,
	output logic              rd_cmd_valid,
	output logic [ADDR_W-1:0] rd_cmd_addr,
	output logic [TAG_W-1:0]  rd_cmd_tag,
	output logic              wr_cmd_valid,
	output logic [ADDR_W-1:0] wr_cmd_addr,
	output logic [DATA_W-1:0] wr_cmd_data,
	output logic              cu_done,
	output logic [CFG_W-1:0]  cu_return,
	output logic              cu_status
);

	logic              slot_free;
	logic [SIZE_W-1:0] done_count;

	cu_job_if job ();

	////////////////////////////////////////////////////////////
	// Pipeline stages
	////////////////////////////////////////////////////////////

	cu_job_latch i_job_latch (
		.clock        (clock),
		.rstn         (rstn),
		.enabled_in   (enabled_in),
		.wed_valid    (wed_valid),
		.wed_src_addr (wed_src_addr),
		.wed_dst_addr (wed_dst_addr),
		.wed_size     (wed_size),
		.cu_configure (cu_configure),
		.job          (job.producer)
	);

	cu_read_issue i_read_issue (
		.clock            (clock),
		.rstn             (rstn),
		.rd_credit_return (rd_credit_return),
		.slot_free        (slot_free),
		.job              (job.consumer),
		.rd_cmd_valid     (rd_cmd_valid),
		.rd_cmd_addr      (rd_cmd_addr),
		.rd_cmd_tag       (rd_cmd_tag)
	);

	cu_write_issue i_write_issue (
		.clock            (clock),
		.rstn             (rstn),
		.wr_credit_return (wr_credit_return),
		.rd_rsp_valid     (rd_rsp_valid),
		.rd_rsp_tag       (rd_rsp_tag),
		.rd_rsp_data      (rd_rsp_data),
		.job              (job.consumer),
		.slot_free        (slot_free),
		.wr_cmd_valid     (wr_cmd_valid),
		.wr_cmd_addr      (wr_cmd_addr),
		.wr_cmd_data      (wr_cmd_data),
		.done_count       (done_count)
	);

	cu_done_tracker i_done_tracker (
		.clock      (clock),
		.rstn       (rstn),
		.done_count (done_count),
		.job        (job.consumer),
		.cu_done    (cu_done),
		.cu_return  (cu_return),
		.cu_status  (cu_status)
	);

endmodule

// File: src/cu_done_tracker.sv
// Completion compare, return count and status outputs

module cu_done_tracker
	import cu_params_pkg::*;
(
	input  logic              clock,
	input  logic              rstn,
	input  logic [SIZE_W-1:0] done_count,
	cu_job_if.consumer        job,
	output logic              cu_done,
	output logic [CFG_W-1:0]  cu_return,
	output logic              cu_status
);

	logic job_complete;

	// Size is only meaningful once the job is captured
	assign job_complete = job.job_valid && (done_count == job.size);

	////////////////////////////////////////////////////////////
	// Status outputs
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			cu_status <= 1'b0;
			cu_done   <= 1'b0;
		end else begin
			cu_status <= job.job_valid;
			// Sticky until the next reset
			if (job_complete) begin
				cu_done <= 1'b1;
			end
		end
	end

	// Count stops moving after the last pop, so this holds at done
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			cu_return <= '0;
		end else begin
			cu_return <= CFG_W'(done_count);
		end
	end

endmodule

// File: src/cu_job_if.sv
// Job interface from the capture stage to the issue and done stages

interface cu_job_if import cu_params_pkg::*; ();

	logic              job_valid;
	logic [ADDR_W-1:0] src_addr;
	logic [ADDR_W-1:0] dst_addr;
	logic [SIZE_W-1:0] size;
	logic              read_en;
	logic              copy_en;

	// Capture stage side
	modport producer (
		output job_valid,
		output src_addr,
		output dst_addr,
		output size,
		output read_en,
		output copy_en
	);

	// Read issue, write issue and done tracking
	modport consumer (
		input job_valid,
		input src_addr,
		input dst_addr,
		input size,
		input read_en,
		input copy_en
	);

endinterface

// File: src/cu_job_latch.sv
// Enable register, job descriptor capture and mode decode

module cu_job_latch
	import cu_params_pkg::*;
	import cu_config_pkg::*;
(
	input  logic              clock,
	input  logic              rstn,
	input  logic              enabled_in,
	input  logic              wed_valid,
	input  logic [ADDR_W-1:0] wed_src_addr,
	input  logic [ADDR_W-1:0] wed_dst_addr,
	input  logic [SIZE_W-1:0] wed_size,
	input  logic [CFG_W-1:0]  cu_configure,
	cu_job_if.producer        job
);

	logic enabled;
	logic capture;

	////////////////////////////////////////////////////////////
	// Enable
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enabled <= 1'b0;
		end else begin
			enabled <= enabled_in;
		end
	end

	// Only the first valid descriptor is taken, one job per reset
	assign capture = enabled && wed_valid && !job.job_valid &&
		(cu_configure != CFG_W'(CFG_IDLE_VALUE));

	////////////////////////////////////////////////////////////
	// Job and mode capture
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			job.job_valid <= 1'b0;
			job.read_en   <= 1'b0;
			job.copy_en   <= 1'b0;
		end else if (capture) begin
			job.job_valid <= 1'b1;
			// Copy mode reads as well
			job.read_en   <= cu_configure[CFG_READ_BIT] | cu_configure[CFG_WRITE_BIT];
			job.copy_en   <= cu_configure[CFG_WRITE_BIT];
		end
	end

	// Descriptor fields are qualified by job_valid downstream
	always_ff @(posedge clock) begin
		if (capture) begin
			job.src_addr <= wed_src_addr;
			job.dst_addr <= wed_dst_addr;
			job.size     <= wed_size;
		end
	end

endmodule

// File: src/cu_params_pkg.sv
// Shared widths, credit limits and in-flight limits of the copy control unit

package cu_params_pkg;

	////////////////////////////////////////////////////////////
	// Datapath widths
	////////////////////////////////////////////////////////////

	// Addresses count cache lines, not bytes
	localparam int unsigned ADDR_W = 64;
	localparam int unsigned SIZE_W = 32;
	localparam int unsigned DATA_W = 64;
	localparam int unsigned TAG_W  = 8;
	localparam int unsigned CFG_W  = 64;

	////////////////////////////////////////////////////////////
	// Flow control limits
	////////////////////////////////////////////////////////////

	// Credits held by each command channel after reset
	localparam int unsigned CMD_CREDITS = 4;

	// Reads outstanding at once, also the response FIFO depth
	// Kept a power of two so the FIFO pointers wrap on their own
	localparam int unsigned INFLIGHT_MAX = 4;

	// Derived counter widths
	localparam int unsigned CREDIT_W   = $clog2(CMD_CREDITS + 1);
	localparam int unsigned INFLIGHT_W = $clog2(INFLIGHT_MAX + 1);
	localparam int unsigned FIFO_PTR_W = $clog2(INFLIGHT_MAX);

endpackage

// File: src/cu_read_issue.sv
// Read command issue with line counter, read credits and in-flight limit

module cu_read_issue
	import cu_params_pkg::*;
(
	input  logic              clock,
	input  logic              rstn,
	input  logic              rd_credit_return,
	input  logic              slot_free,
	cu_job_if.consumer        job,
	output logic              rd_cmd_valid,
	output logic [ADDR_W-1:0] rd_cmd_addr,
	output logic [TAG_W-1:0]  rd_cmd_tag
);

	logic [SIZE_W-1:0]     line_count;
	logic [CREDIT_W-1:0]   credits;
	logic [INFLIGHT_W-1:0] inflight;
	logic                  issue;

	// One read per cycle while lines, credits and FIFO room remain
	assign issue = job.job_valid && job.read_en &&
		(line_count < job.size) &&
		(credits != '0) &&
		(inflight < INFLIGHT_W'(INFLIGHT_MAX));

	////////////////////////////////////////////////////////////
	// Counters
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			line_count   <= '0;
			rd_cmd_valid <= 1'b0;
		end else begin
			rd_cmd_valid <= issue;
			if (issue) begin
				line_count <= line_count + SIZE_W'(1);
			end
		end
	end

	// Credit spent on issue, given back by the host pulse
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			credits <= CREDIT_W'(CMD_CREDITS);
		end else begin
			case ({issue, rd_credit_return})
				2'b10:   credits <= credits - CREDIT_W'(1);
				2'b01:   credits <= credits + CREDIT_W'(1);
				default: credits <= credits;
			endcase
		end
	end

	// Reads on the way, freed as the write stage pops its FIFO
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			inflight <= '0;
		end else begin
			case ({issue, slot_free})
				2'b10:   inflight <= inflight + INFLIGHT_W'(1);
				2'b01:   inflight <= inflight - INFLIGHT_W'(1);
				default: inflight <= inflight;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Command payload
	////////////////////////////////////////////////////////////

	// Tag is the line index, the write side rebuilds the address from it
	always_ff @(posedge clock) begin
		if (issue) begin
			rd_cmd_addr <= job.src_addr + ADDR_W'(line_count);
			rd_cmd_tag  <= line_count[TAG_W-1:0];
		end
	end

endmodule

// File: src/cu_write_issue.sv
// Response FIFO, write credits, write command generation and completion count

module cu_write_issue
	import cu_params_pkg::*;
(
	input  logic              clock,
	input  logic              rstn,
	input  logic              wr_credit_return,
	input  logic              rd_rsp_valid,
	input  logic [TAG_W-1:0]  rd_rsp_tag,
	input  logic [DATA_W-1:0] rd_rsp_data,
	cu_job_if.consumer        job,
	output logic              slot_free,
	output logic              wr_cmd_valid,
	output logic [ADDR_W-1:0] wr_cmd_addr,
	output logic [DATA_W-1:0] wr_cmd_data,
	output logic [SIZE_W-1:0] done_count
);

	logic [TAG_W-1:0]      tag_mem [INFLIGHT_MAX];
	logic [DATA_W-1:0]     data_mem [INFLIGHT_MAX];
	logic [FIFO_PTR_W-1:0] wr_ptr;
	logic [FIFO_PTR_W-1:0] rd_ptr;
	logic [INFLIGHT_W-1:0] fill;
	logic [CREDIT_W-1:0]   credits;
	logic                  fifo_empty;
	logic                  push;
	logic                  pop;

	////////////////////////////////////////////////////////////
	// Response FIFO
	////////////////////////////////////////////////////////////

	// Room is guaranteed by the in-flight limit on the read side
	assign push       = rd_rsp_valid;
	assign fifo_empty = (fill == '0);

	always_ff @(posedge clock) begin
		if (push) begin
			tag_mem[wr_ptr]  <= rd_rsp_tag;
			data_mem[wr_ptr] <= rd_rsp_data;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill   <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + FIFO_PTR_W'(1);
			end
			if (pop) begin
				rd_ptr <= rd_ptr + FIFO_PTR_W'(1);
			end
			case ({push, pop})
				2'b10:   fill <= fill + INFLIGHT_W'(1);
				2'b01:   fill <= fill - INFLIGHT_W'(1);
				default: fill <= fill;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Pop and write command
	////////////////////////////////////////////////////////////

	// Copy mode waits for a credit, read-only mode drains freely
	always_comb begin
		pop = 1'b0;
		if (job.job_valid && !fifo_empty) begin
			pop = job.copy_en ? (credits != '0) : 1'b1;
		end
	end

	assign slot_free    = pop;
	assign wr_cmd_valid = pop && job.copy_en;
	assign wr_cmd_addr  = job.dst_addr + ADDR_W'(tag_mem[rd_ptr]);
	assign wr_cmd_data  = data_mem[rd_ptr];

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			credits <= CREDIT_W'(CMD_CREDITS);
		end else begin
			case ({wr_cmd_valid, wr_credit_return})
				2'b10:   credits <= credits - CREDIT_W'(1);
				2'b01:   credits <= credits + CREDIT_W'(1);
				default: credits <= credits;
			endcase
		end
	end

	// Writes issued in copy mode, responses dropped in read-only mode
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			done_count <= '0;
		end else if (pop) begin
			done_count <= done_count + SIZE_W'(1);
		end
	end

endmodule

// File: testbench/tb_cu_control.sv
// Testbench for the copy control unit with scoreboard, checks and timeout

module tb_cu_control
	import cu_params_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	logic              clock;
	logic              rstn;
	logic              enabled_in;
	logic              wed_valid;
	logic [ADDR_W-1:0] wed_src_addr;
	logic [ADDR_W-1:0] wed_dst_addr;
	logic [SIZE_W-1:0] wed_size;
	logic [CFG_W-1:0]  cu_configure;
	logic              rd_credit_return;
	logic              rd_rsp_valid;
	logic [TAG_W-1:0]  rd_rsp_tag;
	logic [DATA_W-1:0] rd_rsp_data;
	logic              wr_credit_return;
	logic              rd_cmd_valid;
	logic [ADDR_W-1:0] rd_cmd_addr;
	logic [TAG_W-1:0]  rd_cmd_tag;
	logic              wr_cmd_valid;
	logic [ADDR_W-1:0] wr_cmd_addr;
	logic [DATA_W-1:0] wr_cmd_data;
	logic              cu_done;
	logic [CFG_W-1:0]  cu_return;
	logic              cu_status;
	logic [DATA_W-1:0] fill_salt;
	logic              hold_credits;

	// Scoreboard state of the running job
	logic [DATA_W-1:0] exp_data [logic [ADDR_W-1:0]];
	bit                written [logic [ADDR_W-1:0]];
	bit                read_seen [logic [ADDR_W-1:0]];
	logic [ADDR_W-1:0] job_src;
	int unsigned       job_size;
	bit                job_copy;
	bit                job_active;
	bit                done_seen;
	bit                status_seen;
	int                rd_out;
	int                wr_out;
	int                inflight;
	int unsigned       write_count;
	int unsigned       rsp_count;

	string             test_name;
	int unsigned       error_count;
	int unsigned       tests_passed;
	int unsigned       tests_failed;
	int unsigned       cycle_count;
	int unsigned       cycle_limit;

	cu_control_top i_dut (.*);

	tb_mem_model i_mem (
		.clock            (clock),
		.rstn             (rstn),
		.fill_salt        (fill_salt),
		.hold_credits     (hold_credits),
		.rd_cmd_valid     (rd_cmd_valid),
		.rd_cmd_addr      (rd_cmd_addr),
		.rd_cmd_tag       (rd_cmd_tag),
		.wr_cmd_valid     (wr_cmd_valid),
		.rd_rsp_valid     (rd_rsp_valid),
		.rd_rsp_tag       (rd_rsp_tag),
		.rd_rsp_data      (rd_rsp_data),
		.rd_credit_return (rd_credit_return),
		.wr_credit_return (wr_credit_return)
	);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	always @(posedge clock) begin
		cycle_count++;
		if (cycle_count > cycle_limit) begin
			$display("Run stopped after %0d cycles, a test did not finish", cycle_count);
			$display("TEST FAILED");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// Checks and reference model
	////////////////////////////////////////////////////////////

	task automatic expect_equal(input string what, input logic [63:0] exp, input logic [63:0] act);
		assert (exp === act) else begin
			$display("[ERROR] %s %s: expected %h, actual %h", test_name, what, exp, act);
			error_count++;
		end
	endtask

	task automatic require(input bit cond, input string msg);
		assert (cond) else begin
			$display("%s: %s", test_name, msg);
			error_count++;
		end
	endtask

	// Same line contents the host model serves
	function automatic logic [DATA_W-1:0] line_data(input logic [ADDR_W-1:0] addr);
		return (addr * 64'h9e37_79b9_7f4a_7c15) ^ (addr << 29) ^ fill_salt;
	endfunction

	// Bus monitor, samples just before the DUT updates
	always @(posedge clock) begin
		if (rstn) begin
			if (rd_cmd_valid) begin
				rd_out++;
				inflight++;
				require(job_active, "read command issued with no job set up");
				require(cu_status, "read command issued before cu_status rose");
				require(rd_cmd_addr >= job_src && rd_cmd_addr < job_src + ADDR_W'(job_size),
					"read address outside the source range");
				require(!read_seen.exists(rd_cmd_addr), "source line read twice");
				read_seen[rd_cmd_addr] = 1'b1;
				expect_equal("read tag", rd_cmd_addr - job_src, 64'(rd_cmd_tag));
			end
			if (rd_rsp_valid) begin
				inflight--;
				rsp_count++;
			end
			if (rd_credit_return) begin
				rd_out--;
			end
			if (wr_credit_return) begin
				wr_out--;
			end
			if (wr_cmd_valid) begin
				wr_out++;
				write_count++;
				require(job_copy, "write command issued outside copy mode");
				require(exp_data.exists(wr_cmd_addr), "write address outside the destination");
				if (exp_data.exists(wr_cmd_addr)) begin
					expect_equal("write data", exp_data[wr_cmd_addr], wr_cmd_data);
				end
				require(!written.exists(wr_cmd_addr), "destination line written twice");
				written[wr_cmd_addr] = 1'b1;
			end
			require(rd_out <= CMD_CREDITS, "more reads outstanding than read credits");
			require(wr_out <= CMD_CREDITS, "more writes outstanding than write credits");
			require(inflight <= INFLIGHT_MAX, "too many reads waiting for a response");
			if (cu_done && !done_seen) begin
				done_seen = 1'b1;
				require((job_copy ? write_count : rsp_count) == job_size,
					"cu_done rose before the last line was handled");
			end
			if (done_seen) begin
				require(cu_done, "cu_done dropped before reset");
			end
			if (status_seen) begin
				require(cu_status, "cu_status dropped before reset");
			end
			status_seen = status_seen | cu_status;
		end
	end

	////////////////////////////////////////////////////////////
	// Test sequences
	////////////////////////////////////////////////////////////

	task automatic apply_reset();
		@(posedge clock);
		#1;
		rstn         = 1'b0;
		enabled_in   = 1'b0;
		wed_valid    = 1'b0;
		cu_configure = '0;
		hold_credits = 1'b0;
		exp_data.delete();
		written.delete();
		read_seen.delete();
		job_active  = 1'b0;
		done_seen   = 1'b0;
		status_seen = 1'b0;
		rd_out      = 0;
		wr_out      = 0;
		inflight    = 0;
		write_count = 0;
		rsp_count   = 0;
		repeat (2) @(posedge clock);
		#1;
		rstn = 1'b1;
	endtask

	task automatic report_test(input int unsigned errors_before);
		if (error_count == errors_before) begin
			$display("test %s: passed", test_name);
			tests_passed++;
		end else begin
			$display("test %s: failed with %0d errors", test_name, error_count - errors_before);
			tests_failed++;
		end
	endtask

	task automatic run_job(input string name, input int unsigned size, input bit copy,
		input bit throttle);
		logic [CFG_W-1:0] cfg;
		int unsigned      errors_before;
		int unsigned      hold_timer;
		test_name     = name;
		errors_before = error_count;
		apply_reset();
		job_src  = {1'b0, 31'($urandom), $urandom};
		job_size = size;
		job_copy = copy;
		wed_dst_addr = {1'b0, 31'($urandom), $urandom};
		for (int unsigned k = 0; k < size; k++) begin
			exp_data[wed_dst_addr + ADDR_W'(k)] = line_data(job_src + ADDR_W'(k));
		end
		// Unused bits are random, bit 23 is free in copy mode
		cfg     = {$urandom, $urandom};
		cfg[22] = copy;
		if (!copy) begin
			cfg[23] = 1'b1;
		end
		job_active   = 1'b1;
		enabled_in   = 1'b1;
		wed_valid    = 1'b1;
		wed_src_addr = job_src;
		wed_size     = size;
		cu_configure = cfg;
		hold_timer   = 0;
		while (!cu_done) begin
			@(posedge clock);
			#1;
			if (throttle) begin
				if (hold_timer == 0) begin
					hold_credits = !hold_credits;
					hold_timer   = 8 + $urandom_range(16);
				end else begin
					hold_timer--;
				end
			end
		end
		// Count shown in the cycle cu_done rises
		expect_equal("cu_return", 64'(size), cu_return);
		hold_credits = 1'b0;
		repeat (8) @(posedge clock);
		#1;
		expect_equal("lines read", 64'(size), 64'(read_seen.num()));
		expect_equal("lines written", copy ? 64'(size) : 64'd0, 64'(written.num()));
		report_test(errors_before);
	endtask

	task automatic run_gating();
		int unsigned errors_before;
		test_name     = "reset and gating";
		errors_before = error_count;
		apply_reset();
		expect_equal("rd_cmd_valid", 64'd0, 64'(rd_cmd_valid));
		expect_equal("wr_cmd_valid", 64'd0, 64'(wr_cmd_valid));
		expect_equal("cu_done", 64'd0, 64'(cu_done));
		expect_equal("cu_status", 64'd0, 64'(cu_status));
		expect_equal("cu_return", 64'd0, cu_return);
		// Enabled with a valid descriptor but an idle configure word
		enabled_in   = 1'b1;
		wed_valid    = 1'b1;
		wed_size     = 8;
		cu_configure = '0;
		repeat (20) @(posedge clock);
		#1;
		enabled_in = 1'b0;
		repeat (2) @(posedge clock);
		#1;
		cu_configure = CFG_W'(1) << 22;
		repeat (20) @(posedge clock);
		#1;
		require(!cu_status, "job captured while gated");
		report_test(errors_before);
	endtask

	initial begin
		int unsigned size_copy;
		int unsigned size_read;
		int unsigned size_done;
		int unsigned size_slow;
		void'($urandom(35));
		rstn             = 1'b0;
		enabled_in       = 1'b0;
		wed_valid        = 1'b0;
		wed_src_addr     = '0;
		wed_dst_addr     = '0;
		wed_size         = '0;
		cu_configure     = '0;
		hold_credits     = 1'b0;
		error_count      = 0;
		tests_passed     = 0;
		tests_failed     = 0;
		cycle_count      = 0;
		fill_salt = {$urandom, $urandom};
		size_copy = 1 + $urandom_range(39);
		size_read = 1 + $urandom_range(39);
		size_done = 1 + $urandom_range(39);
		size_slow = 16 + $urandom_range(24);
		cycle_limit = 20 * (size_copy + size_read + size_done + size_slow) + 200;

		run_job("copy", size_copy, 1'b1, 1'b0);
		run_job("read only", size_read, 1'b0, 1'b0);
		run_job("completion", size_done, 1'b1, 1'b0);
		run_job("credit back-pressure", size_slow, 1'b1, 1'b1);
		// Reset has to clear the finished job
		run_gating();

		$display("%0d tests passed, %0d failed, %0d errors", tests_passed, tests_failed,
			error_count);
		if (error_count == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// File: testbench/tb_mem_model.sv
// Host model with source memory, out-of-order read responses and credit returns

module tb_mem_model
	import cu_params_pkg::*;
(
	input  logic              clock,
	input  logic              rstn,
	input  logic [DATA_W-1:0] fill_salt,
	input  logic              hold_credits,
	input  logic              rd_cmd_valid,
	input  logic [ADDR_W-1:0] rd_cmd_addr,
	input  logic [TAG_W-1:0]  rd_cmd_tag,
	input  logic              wr_cmd_valid,
	output logic              rd_rsp_valid,
	output logic [TAG_W-1:0]  rd_rsp_tag,
	output logic [DATA_W-1:0] rd_rsp_data,
	output logic              rd_credit_return,
	output logic              wr_credit_return
);

	timeunit 1ns;
	timeprecision 100ps;

	logic [TAG_W-1:0]  pend_tag [$];
	logic [ADDR_W-1:0] pend_addr [$];
	int unsigned       pend_due [$];
	int unsigned       rd_ret_due [$];
	int unsigned       wr_ret_due [$];
	int unsigned       now;
	logic              credits_held;

	// Source memory contents, a scrambled function of the full line address
	function automatic logic [DATA_W-1:0] source_word(input logic [ADDR_W-1:0] addr);
		return (addr * 64'h9e37_79b9_7f4a_7c15) ^ (addr << 29) ^ fill_salt;
	endfunction

	function automatic int first_due(input int unsigned due_q [$]);
		for (int i = 0; i < due_q.size(); i++) begin
			if (due_q[i] <= now) begin
				return i;
			end
		end
		return -1;
	endfunction

	////////////////////////////////////////////////////////////
	// Read responses
	////////////////////////////////////////////////////////////

	// Any due entry may go next, so responses come back out of order
	task automatic send_response();
		int ready [$];
		int pick;
		rd_rsp_valid = 1'b0;
		for (int i = 0; i < pend_due.size(); i++) begin
			if (pend_due[i] <= now) begin
				ready.push_back(i);
			end
		end
		if (rstn && ready.size() != 0) begin
			pick = ready[$urandom_range(ready.size() - 1)];
			rd_rsp_valid = 1'b1;
			rd_rsp_tag   = pend_tag[pick];
			rd_rsp_data  = source_word(pend_addr[pick]);
			pend_tag.delete(pick);
			pend_addr.delete(pick);
			pend_due.delete(pick);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Credit returns
	////////////////////////////////////////////////////////////

	task automatic return_credits();
		int rd_idx;
		int wr_idx;
		rd_idx = first_due(rd_ret_due);
		wr_idx = first_due(wr_ret_due);
		rd_credit_return = 1'b0;
		wr_credit_return = 1'b0;
		if (rstn && !credits_held) begin
			if (rd_idx >= 0) begin
				rd_credit_return = 1'b1;
				rd_ret_due.delete(rd_idx);
			end
			if (wr_idx >= 0) begin
				wr_credit_return = 1'b1;
				wr_ret_due.delete(wr_idx);
			end
		end
	endtask

	initial begin
		rd_rsp_valid     = 1'b0;
		rd_rsp_tag       = '0;
		rd_rsp_data      = '0;
		rd_credit_return = 1'b0;
		wr_credit_return = 1'b0;
		credits_held     = 1'b0;
		now              = 0;
		forever begin
			@(posedge clock);
			now++;
			// Hold request as it stood at the clock edge
			credits_held = hold_credits;
			if (!rstn) begin
				pend_tag.delete();
				pend_addr.delete();
				pend_due.delete();
				rd_ret_due.delete();
				wr_ret_due.delete();
			end else begin
				if (rd_cmd_valid) begin
					pend_tag.push_back(rd_cmd_tag);
					pend_addr.push_back(rd_cmd_addr);
					pend_due.push_back(now + 1 + $urandom_range(7));
					rd_ret_due.push_back(now + $urandom_range(3));
				end
				if (wr_cmd_valid) begin
					wr_ret_due.push_back(now + $urandom_range(3));
				end
			end
			#1;
			send_response();
			return_credits();
		end
	end

endmodule

// File: vlog.f
src/cu_params_pkg.sv
src/cu_config_pkg.sv
src/cu_job_if.sv
src/cu_job_latch.sv
src/cu_read_issue.sv
src/cu_write_issue.sv
src/cu_done_tracker.sv
src/cu_control_top.sv
testbench/tb_mem_model.sv
testbench/tb_cu_control.sv
